// File: src.f
logic/sap_pkg.sv
logic/sap_programmer.sv
logic/sap_controller.sv
logic/sap_datapath.sv
logic/sap_top.sv
bench/sap_assertions.sv
bench/sap_checker.sv
bench/sap_tb.sv

// File: bench/sap_tb.sv
// ====================
// SAP-1 testbench
// Clock, reset, front-panel loading
// Reference interpreter, fixed and random programs
// ====================
module sap_tb;
  timeunit 1ns;
  timeprecision 100ps;

  typedef logic [7:0] out_list_t [$];

  logic                 clk;
  logic                 arst_n;
  logic                 programming;
  logic                 new_byte;
  logic [7:0]           ui_in;
  logic                 busy;
  sap_pkg::cpu_status_t status;
  int                   checker_errors;
  int                   timeouts;
  integer               seed;
  logic [7:0]           image [16];     // Program image from address 0 up
  logic [7:0]           ram_copy [16];  // Expected DUT RAM contents

  sap_top i_dut (
    .clk         (clk),
    .arst_n      (arst_n),
    .programming (programming),
    .new_byte    (new_byte),
    .ui_in       (ui_in),
    .busy        (busy),
    .status      (status)
  );

  sap_checker i_checker (
    .clk    (clk),
    .arst_n (arst_n),
    .status (status),
    .errors (checker_errors)
  );

  bind sap_top sap_assertions i_assertions (
    .clk         (clk),
    .arst_n      (arst_n),
    .programming (programming),
    .busy        (busy),
    .status      (status)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic tick();
    @(posedge clk);
    #1;  // Drive point
  endtask

  // Reference interpreter with opcode in the high nibble and address in the low
  function automatic out_list_t sap_model(input logic [7:0] mem [16]);
    out_list_t  outs;
    logic [7:0] acc;
    logic [7:0] instr;
    logic [3:0] pc;
    int         steps;
    bit         stop;
    acc   = 8'h00;
    pc    = 4'h0;
    steps = 0;
    stop  = 1'b0;
    while (!stop && steps < 64) begin
      instr = mem[pc];
      pc    = pc + 4'h1;  // Wraps at 16
      case (instr[7:4])
        4'h0:    acc = mem[instr[3:0]];
        4'h1:    acc = acc + mem[instr[3:0]];  // Mod 256
        4'h2:    acc = acc - mem[instr[3:0]];
        4'he:    outs.push_back(acc);
        4'hf:    stop = 1'b1;
        default: ;  // No-op
      endcase
      steps++;
    end
    return outs;
  endfunction

  task automatic set_image(input logic [127:0] bytes);
    int i;
    for (i = 0; i < 16; i++) image[i] = bytes[127 - 8*i -: 8];  // MSB byte is address 0
  endtask

  // LDA 12, three ADD/SUB + OUT pairs on 13..15, HLT, random data
  task automatic build_random_image(input int mode);
    logic [3:0] op;
    int         i;
    image[0] = 8'h0c;
    for (i = 1; i <= 3; i++) begin
      case (mode)
        0:       op = 4'h1;
        1:       op = 4'h2;
        default: op = ($random(seed) & 1) ? 4'h1 : 4'h2;
      endcase
      image[2*i-1] = {op, 4'(12 + i)};
      image[2*i]   = 8'he0;
    end
    image[7] = 8'hf0;
    for (i = 8; i < 16; i++) image[i] = 8'($random(seed));
  endtask

  task automatic wait_busy_low();
    int n;
    n = 0;
    while (busy && n < 20) begin
      tick();
      n++;
    end
    if (busy) begin
      timeouts++;
      $display("Timeout at %0t: programmer stayed busy", $time);
    end
  endtask

  task automatic wait_halted(input logic level, input int limit);
    int n;
    n = 0;
    while (status.halted !== level && n < limit) begin
      tick();
      n++;
    end
    if (status.halted !== level) begin
      timeouts++;
      $display("Timeout at %0t: halted never went to %0b", $time, level);
    end
  endtask

  // Strobe one byte and optionally a second one while busy
  task automatic send_byte(input logic [7:0] value, input bit extra);
    ui_in    = value;
    new_byte = 1'b1;
    tick();
    new_byte = 1'b0;
    if (extra) begin
      tick();
      ui_in    = 8'hf0;  // HLT if it were stored
      new_byte = 1'b1;
      tick();
      new_byte = 1'b0;
    end
    wait_busy_low();
  endtask

  // Loads the first n_bytes of the image, the rest of RAM keeps older data
  task automatic run_program(input int n_bytes, input int junk_at, input string name);
    out_list_t outs;
    int        i;
    for (i = 0; i < n_bytes; i++) ram_copy[i] = image[i];
    outs = sap_model(ram_copy);
    foreach (outs[k]) i_checker.push_expected(outs[k]);
    programming = 1'b1;
    wait_halted(1'b0, 4);  // New load clears halt
    tick();
    for (i = 0; i < n_bytes; i++) send_byte(image[i], i == junk_at);
    tick();
    programming = 1'b0;
    wait_halted(1'b1, 200);
    repeat (8) tick();  // Quiet window after HLT
    i_checker.check_drained(name);
  endtask

  initial begin
    int r;
    arst_n      = 1'b0;
    programming = 1'b0;
    new_byte    = 1'b0;
    ui_in       = 8'h00;
    timeouts    = 0;
    seed        = 32'h05e2_c492;
    repeat (5) @(posedge clk);
    #1 arst_n = 1'b1;
    tick();
    set_image(128'h09e0_1ae0_2be0_70f0_e02c_0f60_0000_0000);  // OUTs, no-op, HLT
    run_program(16, -1, "fixed");
    set_image(128'h0b2a_e019_e018_e0f0_0000_0000_0000_0000);  // Uses data left at 8..11
    run_program(8, -1, "partial load");
    set_image(128'h0d1e_e02f_e01f_e0f0_0000_0000_00f0_2030);  // Load must restart at 0
    run_program(16, 2, "dropped strobe");
    for (r = 0; r < 12; r++) begin
      build_random_image(r % 3);  // ADD, SUB, mixed
      run_program(16, -1, "random");
    end
    $display("Error counts: checker %0d, timeout %0d, assertion %0d",
             checker_errors, timeouts, i_dut.i_assertions.fail_count);
    if (checker_errors + timeouts + i_dut.i_assertions.fail_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: bench/sap_checker.sv
// ====================
// Output checker
// Expected queue, out_valid compare
// ====================
module sap_checker (
  input  logic                 clk,
  input  logic                 arst_n,
  input  sap_pkg::cpu_status_t status,
  output int                   errors
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [7:0] expected_q [$];  // Filled by the testbench from the model

  initial errors = 0;

  task automatic push_expected(input logic [7:0] value);
    expected_q.push_back(value);
  endtask

  // Called once the program is halted and quiet
  task automatic check_drained(input string name);
    if (expected_q.size() != 0) begin
      errors++;
      $display("Program '%s' halted with %0d expected outputs never seen",
               name, expected_q.size());
    end
    expected_q.delete();
  endtask

  // Mid-cycle sample, registers settled
  always @(negedge clk) begin
    logic [7:0] expected;
    if (arst_n && status.out_valid) begin
      if (expected_q.size() == 0) begin
        errors++;
        $display("Output %02h at %0t arrived when no output was expected",
                 status.out_value, $time);
      end else begin
        expected = expected_q.pop_front();
        if (status.out_value !== expected) begin
          errors++;
          $display("[FAIL] %0t out_value %02h, expected %02h",
                   $time, status.out_value, expected);
        end
      end
    end
  end

endmodule

// File: bench/sap_assertions.sv
// ====================
// SAP-1 bound assertions
// Busy, out_valid and halt rules
// ====================
module sap_assertions (
  input logic                 clk,
  input logic                 arst_n,
  input logic                 programming,
  input logic                 busy,
  input sap_pkg::cpu_status_t status
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count;  // Read by the testbench

  initial fail_count = 0;

  busy_only_loading: assert property (@(posedge clk) disable iff (!arst_n)
    !programming |-> !busy)
    else begin
      fail_count++;
      $error("busy high while programming is low");
    end

  valid_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
    status.out_valid |=> !status.out_valid)
    else begin
      fail_count++;
      $error("out_valid held longer than one cycle");
    end

  quiet_after_halt: assert property (@(posedge clk) disable iff (!arst_n)
    status.halted |-> !status.out_valid)
    else begin
      fail_count++;
      $error("out_valid seen while halted");
    end

endmodule

// File: logic/sap_top.sv
// ==================
// SAP-1 top level
// Programmer, controller, datapath
// ==================
module sap_top (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       programming,
  input  logic                       new_byte,
  input  logic [sap_pkg::data_w-1:0] ui_in,
  output logic                       busy,
  output sap_pkg::cpu_status_t       status
);

  sap_pkg::ctrl_word_t        prog_ctrl;  // Loader micro-word
  logic [sap_pkg::data_w-1:0] prog_bus;   // Loader bus value
  sap_pkg::ctrl_word_t        ctrl;       // Active control word
  sap_pkg::opcode_t           opcode;
  sap_pkg::cpu_status_t       dp_status;  // Datapath part of status
  logic                       halted;

  sap_programmer i_programmer (
    .clk         (clk),
    .arst_n      (arst_n),
    .programming (programming),
    .new_byte    (new_byte),
    .ui_in       (ui_in),
    .busy        (busy),
    .prog_ctrl   (prog_ctrl),
    .prog_bus    (prog_bus)
  );

  sap_controller i_controller (
    .clk         (clk),
    .arst_n      (arst_n),
    .programming (programming),
    .prog_ctrl   (prog_ctrl),
    .opcode      (opcode),
    .ctrl        (ctrl),
    .halted      (halted)
  );

  sap_datapath i_datapath (
    .clk         (clk),
    .arst_n      (arst_n),
    .programming (programming),
    .ctrl        (ctrl),
    .prog_bus    (prog_bus),
    .opcode      (opcode),
    .status      (dp_status)
  );

  // Output fields from the datapath, halt flag from the controller
  assign status = '{out_value: dp_status.out_value,
                    out_valid: dp_status.out_valid,
                    halted:    halted};

endmodule

// File: logic/sap_datapath.sv
// ==================
// SAP-1 datapath
// PC, MAR, RAM, IR, A, B, ALU, output, bus mux
// ==================
module sap_datapath (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       programming,
  input  sap_pkg::ctrl_word_t        ctrl,
  input  logic [sap_pkg::data_w-1:0] prog_bus,
  output sap_pkg::opcode_t           opcode,
  output sap_pkg::cpu_status_t       status
);

  localparam int pad_w = sap_pkg::data_w - sap_pkg::addr_w;  // Zero fill for 4-bit sources

  logic [sap_pkg::addr_w-1:0] pc;
  logic [sap_pkg::addr_w-1:0] mar;       // RAM address
  logic [sap_pkg::data_w-1:0] mdr;       // Memory data waiting to be written
  logic [sap_pkg::data_w-1:0] ir;
  logic [sap_pkg::data_w-1:0] a;         // Accumulator
  logic [sap_pkg::data_w-1:0] b;
  logic [sap_pkg::data_w-1:0] out_q;
  logic                       out_valid_q;
  logic [sap_pkg::data_w-1:0] alu;       // Add or subtract, modulo 256
  logic [sap_pkg::data_w-1:0] cpu_bus;   // Enabled CPU source
  logic [sap_pkg::data_w-1:0] bus;       // What the registers see
  logic [sap_pkg::data_w-1:0] ram [sap_pkg::ram_depth];

  assign alu = ctrl.sub ? a - b : a + b;  // Carry dropped

  // One-hot AND-OR select, only one enable at a time
  assign cpu_bus = ({sap_pkg::data_w{ctrl.pc_en}}  & {{pad_w{1'b0}}, pc})
                 | ({sap_pkg::data_w{ctrl.ram_en}} & ram[mar])
                 | ({sap_pkg::data_w{ctrl.ir_en}}  & {{pad_w{1'b0}}, ir[sap_pkg::addr_w-1:0]})
                 | ({sap_pkg::data_w{ctrl.a_en}}   & a)
                 | ({sap_pkg::data_w{ctrl.b_en}}   & alu);

  assign bus = programming ? prog_bus : cpu_bus;  // Front panel wins while loading

  // Program counter, restarts at 0 for each run
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= '0;
    end else if (programming) begin
      pc <= '0;
    end else if (ctrl.pc_load) begin
      pc <= bus[sap_pkg::addr_w-1:0];
    end else if (ctrl.pc_inc) begin
      pc <= pc + 1'b1;  // Wraps at 16
    end
  end

  // Memory address and data registers, used by both loader and CPU
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mar <= '0;
      mdr <= '0;
    end else begin
      if (ctrl.mar_addr_load) mar <= bus[sap_pkg::addr_w-1:0];
      if (ctrl.mar_mem_load)  mdr <= bus;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.ram_load) ram[mar] <= mdr;  // Write port
  end

  // IR, A, B start clean for each run
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ir <= '0;
      a  <= '0;
      b  <= '0;
    end else if (programming) begin
      ir <= '0;
      a  <= '0;
      b  <= '0;
    end else begin
      if (ctrl.ir_load) ir <= bus;
      if (ctrl.a_load)  a  <= bus;
      if (ctrl.b_load)  b  <= bus;
    end
  end

  // Output register holds its value across runs
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_q       <= '0;
      out_valid_q <= 1'b0;
    end else begin
      out_valid_q <= ctrl.out_load;  // Pulse the cycle after load
      if (ctrl.out_load) out_q <= bus;
    end
  end

  assign opcode = sap_pkg::opcode_t'(ir[sap_pkg::data_w-1:sap_pkg::addr_w]);  // High nibble

  assign status = '{out_value: out_q, out_valid: out_valid_q, halted: 1'b0};  // Top fills halted

endmodule

// File: logic/sap_controller.sv
// ==================
// SAP-1 controller
// Ring counter, microcode decode, halt latch
// ==================
module sap_controller (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                programming,
  input  sap_pkg::ctrl_word_t prog_ctrl,
  input  sap_pkg::opcode_t    opcode,
  output sap_pkg::ctrl_word_t ctrl,
  output logic                halted
);

  sap_pkg::tstate_t    state;       // Ring counter
  sap_pkg::ctrl_word_t micro_word;  // Decoded word for the CPU

  // Six-state ring, one idle cycle after loading ends
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= sap_pkg::t_hold;
      halted <= 1'b0;
    end else if (programming) begin  // Parked while loading, new run clears halt
      state  <= sap_pkg::t_hold;
      halted <= 1'b0;
    end else if (!halted) begin  // Frozen after HLT
      case (state)
        sap_pkg::t_hold: state <= sap_pkg::t0;
        sap_pkg::t5:     state <= sap_pkg::t0;
        sap_pkg::t3: begin
          if (opcode == sap_pkg::op_hlt) begin
            halted <= 1'b1;
            state  <= sap_pkg::t_hold;  // Park with idle word
          end else begin
            state <= sap_pkg::t4;
          end
        end
        default: state <= sap_pkg::tstate_t'(state + 3'd1);
      endcase
    end
  end

  always_comb begin
    micro_word = sap_pkg::ctrl_idle;
    case (state)
      sap_pkg::t0: begin  // MAR <= PC
        micro_word.pc_en         = 1'b1;
        micro_word.mar_addr_load = 1'b1;
      end
      sap_pkg::t1: micro_word.pc_inc = 1'b1;  // PC++
      sap_pkg::t2: begin  // IR <= RAM[MAR]
        micro_word.ram_en  = 1'b1;
        micro_word.ir_load = 1'b1;
      end
      sap_pkg::t3: begin
        case (opcode)
          sap_pkg::op_lda, sap_pkg::op_add, sap_pkg::op_sub: begin
            micro_word.ir_en         = 1'b1;  // Operand address to MAR
            micro_word.mar_addr_load = 1'b1;
          end
          sap_pkg::op_out: begin
            micro_word.a_en     = 1'b1;  // A to output register
            micro_word.out_load = 1'b1;
          end
          default: ;  // HLT handled in ring, others no-op
        endcase
      end
      sap_pkg::t4: begin
        case (opcode)
          sap_pkg::op_lda: begin
            micro_word.ram_en = 1'b1;  // A <= mem
            micro_word.a_load = 1'b1;
          end
          sap_pkg::op_add, sap_pkg::op_sub: begin
            micro_word.ram_en = 1'b1;  // B <= mem
            micro_word.b_load = 1'b1;
          end
          default: ;
        endcase
      end
      sap_pkg::t5: begin
        case (opcode)
          sap_pkg::op_add: begin
            micro_word.b_en   = 1'b1;  // A <= A + B
            micro_word.a_load = 1'b1;
          end
          sap_pkg::op_sub: begin
            micro_word.b_en   = 1'b1;  // A <= A - B
            micro_word.sub    = 1'b1;
            micro_word.a_load = 1'b1;
          end
          default: ;
        endcase
      end
      default: ;  // t_hold stays idle
    endcase
  end

  // Programmer owns the control lines while loading
  assign ctrl = programming ? prog_ctrl : micro_word;

endmodule

// File: logic/sap_programmer.sv
// ==================
// Front-panel programmer
// Writes each switch byte to the next RAM word
// ==================
module sap_programmer (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      programming,
  input  logic                      new_byte,
  input  logic [sap_pkg::data_w-1:0] ui_in,
  output logic                      busy,
  output sap_pkg::ctrl_word_t       prog_ctrl,
  output logic [sap_pkg::data_w-1:0] prog_bus
);

  logic                       programming_d;  // For rising edge of programming
  logic                       new_byte_d;     // For rising edge of strobe
  logic                       prog_rise;
  logic                       accept;         // Strobe taken
  sap_pkg::tstate_t           stage;
  logic [sap_pkg::addr_w-1:0] load_addr;      // Next RAM word to fill
  logic [sap_pkg::data_w-1:0] byte_q;         // Captured switch byte

  assign prog_rise = programming && !programming_d;
  // Strobes during a byte are dropped
  assign accept    = programming && new_byte && !new_byte_d && !busy;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      programming_d <= 1'b0;
      new_byte_d    <= 1'b0;
      busy          <= 1'b0;
      stage         <= sap_pkg::t_hold;
    end else begin
      programming_d <= programming;
      new_byte_d    <= new_byte;
      if (!programming) begin  // Leaving load mode aborts any byte
        busy  <= 1'b0;
        stage <= sap_pkg::t_hold;
      end else if (accept) begin
        busy  <= 1'b1;
        stage <= sap_pkg::t0;
      end else if (busy) begin
        if (stage == sap_pkg::t5) begin  // Last stage, ready for next byte
          busy  <= 1'b0;
          stage <= sap_pkg::t_hold;
        end else begin
          stage <= sap_pkg::tstate_t'(stage + 3'd1);
        end
      end
    end
  end

  // Load address restarts at 0 on each new load session, wraps at 16
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      load_addr <= '0;
    end else if (prog_rise) begin
      load_addr <= '0;
    end else if (busy && stage == sap_pkg::t1) begin
      load_addr <= load_addr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) byte_q <= ui_in;  // Switch byte
  end

  always_comb begin
    prog_ctrl = sap_pkg::ctrl_idle;
    prog_bus  = '0;
    case (stage)
      sap_pkg::t0: begin  // MAR <= load address
        prog_ctrl.mar_addr_load = 1'b1;
        prog_bus = {{(sap_pkg::data_w - sap_pkg::addr_w){1'b0}}, load_addr};
      end
      sap_pkg::t4: begin  // Memory data register <= byte
        prog_ctrl.mar_mem_load = 1'b1;
        prog_bus = byte_q;
      end
      sap_pkg::t5: prog_ctrl.ram_load = 1'b1;  // Commit to RAM
      default: ;  // t1 bumps address, t2/t3 idle
    endcase
  end

endmodule

// File: logic/sap_pkg.sv
// ==================
// Shared SAP-1 definitions
// Sizes, control word, opcodes, stages, status bundle
// ==================
package sap_pkg;

  localparam int data_w    = 8;   // Data and bus width
  localparam int addr_w    = 4;   // RAM address width
  localparam int ram_depth = 16;  // RAM words

  // Fifteen control lines, all active high
  typedef struct packed {
    logic pc_inc;         // Program counter increment
    logic pc_en;          // PC onto bus
    logic pc_load;        // PC from bus
    logic mar_addr_load;  // MAR address from bus
    logic mar_mem_load;   // Memory data register from bus
    logic ram_en;         // RAM word onto bus
    logic ram_load;       // Write memory data into RAM
    logic ir_load;        // IR from bus
    logic ir_en;          // IR operand onto bus
    logic a_load;         // Accumulator from bus
    logic a_en;           // Accumulator onto bus
    logic sub;            // ALU subtracts
    logic b_en;           // ALU result onto bus
    logic b_load;         // B register from bus
    logic out_load;       // Output register from bus
  } ctrl_word_t;

  localparam ctrl_word_t ctrl_idle = '0;  // Nothing asserted

  typedef enum logic [3:0] {
    op_lda = 4'h0,  // A <= mem
    op_add = 4'h1,  // A <= A + mem
    op_sub = 4'h2,  // A <= A - mem
    op_out = 4'he,  // Out <= A
    op_hlt = 4'hf   // Stop
  } opcode_t;

  // Micro-sequence stages, shared by programmer and controller
  typedef enum logic [2:0] {
    t0     = 3'd0,
    t1     = 3'd1,
    t2     = 3'd2,
    t3     = 3'd3,
    t4     = 3'd4,
    t5     = 3'd5,
    t_hold = 3'd6   // Parked, nothing running
  } tstate_t;

  // Result bundle seen at the top level
  typedef struct packed {
    logic [data_w-1:0] out_value;  // Output register contents
    logic              out_valid;  // One cycle after an OUT load
    logic              halted;     // Set by HLT
  } cpu_status_t;

endpackage
